//--- alu_pkg.sv
package alu_pkg;

   // datapath widths
   localparam int data_w   = 64;
   localparam int scalar_w = 32;
   localparam int flag_w   = 6;

   // flag bit positions in set_eflags / eflags_out
   localparam int flag_of = 5;
   localparam int flag_sf = 4;
   localparam int flag_zf = 3;
   localparam int flag_af = 2;
   localparam int flag_cf = 1;
   localparam int flag_pf = 0;

   // operand size codes, anything else is treated as 32 bit
   localparam logic [2:0] size_8  = 3'd1;
   localparam logic [2:0] size_16 = 3'd2;
   localparam logic [2:0] size_32 = 3'd3;

   // alu operation codes, unused codes behave as pass
   localparam logic [3:0] op_pass  = 4'd0;
   localparam logic [3:0] op_add   = 4'd1;
   localparam logic [3:0] op_and   = 4'd2;
   localparam logic [3:0] op_not   = 4'd7;
   localparam logic [3:0] op_or    = 4'd8;
   localparam logic [3:0] op_paddw = 4'd9;
   localparam logic [3:0] op_paddd = 4'd10;
   localparam logic [3:0] op_pcmp  = 4'd11;
   localparam logic [3:0] op_sal   = 4'd12;
   localparam logic [3:0] op_sar   = 4'd13;

   // opcode that turns the packed compare into a min
   localparam logic [15:0] opc_pminsw = 16'h0fea;

   // shift count is taken from the low bits of b
   localparam int shift_count_w = 5;

   // operand word, scalar view or simd lanes
   typedef union packed {
      logic [data_w-1:0]  word;
      logic [3:0][15:0]   w16;
      logic [1:0][31:0]   w32;
   } alu_word_u;

   // low-bit mask for the operand size
   function automatic logic [scalar_w-1:0] size_mask(input logic [2:0] opsize);
      case (opsize)
         size_8:  size_mask = 32'h0000_00ff;
         size_16: size_mask = 32'h0000_ffff;
         default: size_mask = 32'hffff_ffff;
      endcase
   endfunction

   // operand width in bits for the size code
   function automatic logic [5:0] size_width(input logic [2:0] opsize);
      case (opsize)
         size_8:  size_width = 6'd8;
         size_16: size_width = 6'd16;
         default: size_width = 6'd32;
      endcase
   endfunction

endpackage

//--- int_adder.sv
`timescale 1ns/1ps

module int_adder #(
   parameter int data_w = alu_pkg::data_w
) (
   input  alu_pkg::alu_word_u          a,
   input  alu_pkg::alu_word_u          b,
   input  logic [2:0]                  opsize,
   output logic [data_w-1:0]           result,
   output logic [alu_pkg::flag_w-1:0]  flags,
   output logic [alu_pkg::flag_w-1:0]  flag_mask
);

   // one 32 bit add, narrower sizes read from its carry chain
   logic [alu_pkg::scalar_w:0]   sum;
   // carry into each bit position
   logic [alu_pkg::scalar_w-1:0] carry_in;
   logic [alu_pkg::scalar_w-1:0] sized;
   logic                         cf;
   logic                         of;
   logic                         sf;

   always_comb begin
      sum = {1'b0, a.word[alu_pkg::scalar_w-1:0]} + {1'b0, b.word[alu_pkg::scalar_w-1:0]};
      // sum bit = a ^ b ^ carry, so recover the carries
      carry_in = sum[alu_pkg::scalar_w-1:0] ^ a.word[alu_pkg::scalar_w-1:0]
                 ^ b.word[alu_pkg::scalar_w-1:0];
      sized = sum[alu_pkg::scalar_w-1:0] & alu_pkg::size_mask(opsize);

      // carry out of the size, overflow is carry into msb vs carry out
      case (opsize)
         alu_pkg::size_8: begin
            cf = carry_in[8];
            of = carry_in[8] ^ carry_in[7];
            sf = sum[7];
         end
         alu_pkg::size_16: begin
            cf = carry_in[16];
            of = carry_in[16] ^ carry_in[15];
            sf = sum[15];
         end
         default: begin
            cf = sum[alu_pkg::scalar_w];
            of = sum[alu_pkg::scalar_w] ^ carry_in[alu_pkg::scalar_w-1];
            sf = sum[alu_pkg::scalar_w-1];
         end
      endcase
   end

   // zero extend the sized sum
   always_comb begin
      result = '0;
      result[alu_pkg::scalar_w-1:0] = sized;
   end

   always_comb begin
      flags = '0;
      flags[alu_pkg::flag_of] = of;
      flags[alu_pkg::flag_sf] = sf;
      flags[alu_pkg::flag_zf] = (sized == '0);
      // nibble carry
      flags[alu_pkg::flag_af] = carry_in[4];
      flags[alu_pkg::flag_cf] = cf;
   end

   // add writes every flag, pf is filled in later
   assign flag_mask = '1;

endmodule

//--- logic_unit.sv
`timescale 1ns/1ps

module logic_unit #(
   parameter int data_w = alu_pkg::data_w
) (
   input  alu_pkg::alu_word_u          a,
   input  alu_pkg::alu_word_u          b,
   input  logic [2:0]                  opsize,
   input  logic [3:0]                  alu_op,
   output logic [data_w-1:0]           result,
   output logic [alu_pkg::flag_w-1:0]  flags,
   output logic [alu_pkg::flag_w-1:0]  flag_mask
);

   logic [alu_pkg::scalar_w-1:0] raw;
   logic [alu_pkg::scalar_w-1:0] sized;
   logic                         sf;

   always_comb begin
      case (alu_op)
         alu_pkg::op_or:  raw = a.word[alu_pkg::scalar_w-1:0] | b.word[alu_pkg::scalar_w-1:0];
         alu_pkg::op_not: raw = ~a.word[alu_pkg::scalar_w-1:0];
         default:         raw = a.word[alu_pkg::scalar_w-1:0] & b.word[alu_pkg::scalar_w-1:0];
      endcase
      sized = raw & alu_pkg::size_mask(opsize);
   end

   // sign bit at the operand size
   always_comb begin
      case (opsize)
         alu_pkg::size_8:  sf = sized[7];
         alu_pkg::size_16: sf = sized[15];
         default:          sf = sized[alu_pkg::scalar_w-1];
      endcase
   end

   always_comb begin
      result = '0;
      result[alu_pkg::scalar_w-1:0] = sized;
   end

   // of and cf cleared, af left alone
   always_comb begin
      flags     = '0;
      flag_mask = '0;
      if (alu_op != alu_pkg::op_not) begin
         flags[alu_pkg::flag_sf] = sf;
         flags[alu_pkg::flag_zf] = (sized == '0);
         flag_mask = '1;
         flag_mask[alu_pkg::flag_af] = 1'b0;
      end
   end

endmodule

//--- shifter.sv
`timescale 1ns/1ps

module shifter #(
   parameter int data_w = alu_pkg::data_w
) (
   input  alu_pkg::alu_word_u          a,
   input  alu_pkg::alu_word_u          b,
   input  logic [2:0]                  opsize,
   input  logic [3:0]                  alu_op,
   output logic [data_w-1:0]           result,
   output logic [alu_pkg::flag_w-1:0]  flags,
   output logic [alu_pkg::flag_w-1:0]  flag_mask
);

   logic [alu_pkg::shift_count_w-1:0] count;
   logic [5:0]                        width;
   logic [alu_pkg::scalar_w-1:0]      mask;
   logic [alu_pkg::scalar_w-1:0]      src;
   // operand sign extended to 32 bits for sar
   logic [alu_pkg::scalar_w-1:0]      src_sext;
   // one extra bit catches the last bit out of a 32 bit sal
   logic [alu_pkg::scalar_w:0]        sal_wide;
   logic [alu_pkg::scalar_w-1:0]      sar_wide;
   logic [alu_pkg::scalar_w-1:0]      sized;
   logic                              sign;
   logic                              cf;
   logic                              of;
   logic                              sf;

   assign count = b.word[alu_pkg::shift_count_w-1:0];
   assign width = alu_pkg::size_width(opsize);
   assign mask  = alu_pkg::size_mask(opsize);

   always_comb begin
      src      = a.word[alu_pkg::scalar_w-1:0] & mask;
      sign     = src[width-1];
      src_sext = sign ? (src | ~mask) : src;
      sal_wide = {1'b0, src} << count;
      sar_wide = $signed(src_sext) >>> count;

      if (alu_op == alu_pkg::op_sar) begin
         // sign fill, wide counts leave only sign bits
         sized = sar_wide & mask;
         cf    = (count == '0) ? 1'b0 : src_sext[count-1];
         of    = 1'b0;
      end else begin
         sized = sal_wide[alu_pkg::scalar_w-1:0] & mask;
         // nothing left to shift out once count reaches the width
         cf    = ({1'b0, count} >= width) ? 1'b0 : sal_wide[width];
         of    = sized[width-1] ^ cf;
      end
      sf = sized[width-1];
   end

   // count zero leaves a untouched
   always_comb begin
      result = a.word;
      if (count != '0) begin
         result = '0;
         result[alu_pkg::scalar_w-1:0] = sized;
      end
   end

   always_comb begin
      flags     = '0;
      flag_mask = '0;
      if (count != '0) begin
         flags[alu_pkg::flag_sf]     = sf;
         flags[alu_pkg::flag_zf]     = (sized == '0);
         flags[alu_pkg::flag_cf]     = cf;
         flag_mask[alu_pkg::flag_sf] = 1'b1;
         flag_mask[alu_pkg::flag_zf] = 1'b1;
         flag_mask[alu_pkg::flag_cf] = 1'b1;
         flag_mask[alu_pkg::flag_pf] = 1'b1;
         // of only defined for single bit shifts
         if (count == 1) begin
            flags[alu_pkg::flag_of]     = of;
            flag_mask[alu_pkg::flag_of] = 1'b1;
         end
      end
   end

endmodule

//--- simd_unit.sv
`timescale 1ns/1ps

module simd_unit #(
   parameter int data_w = alu_pkg::data_w
) (
   input  alu_pkg::alu_word_u  a,
   input  alu_pkg::alu_word_u  b,
   input  logic [3:0]          alu_op,
   input  logic [15:0]         opcode,
   output logic [data_w-1:0]   result
);

   alu_pkg::alu_word_u paddw;
   alu_pkg::alu_word_u paddd;
   alu_pkg::alu_word_u pcmp;
   // pminsw picks the smaller lane, everything else the larger
   logic               use_min;
   logic [3:0]         a_gt;

   assign use_min = (opcode == alu_pkg::opc_pminsw);

   // word lanes, carries between lanes dropped
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         paddw.w16[i] = a.w16[i] + b.w16[i];
      end
   end

   // dword lanes
   always_comb begin
      for (int i = 0; i < 2; i++) begin
         paddd.w32[i] = a.w32[i] + b.w32[i];
      end
   end

   // signed compare per word lane
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         a_gt[i] = $signed(a.w16[i]) > $signed(b.w16[i]);
         if (use_min) begin
            pcmp.w16[i] = a_gt[i] ? b.w16[i] : a.w16[i];
         end else begin
            pcmp.w16[i] = a_gt[i] ? a.w16[i] : b.w16[i];
         end
      end
   end

   always_comb begin
      case (alu_op)
         alu_pkg::op_paddw: result = paddw.word;
         alu_pkg::op_paddd: result = paddd.word;
         default:           result = pcmp.word;
      endcase
   end

endmodule

//--- alu_result_stage.sv
`timescale 1ns/1ps

module alu_result_stage #(
   parameter int data_w = alu_pkg::data_w
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic [3:0]                  alu_op,
   input  alu_pkg::alu_word_u          a,
   input  logic [data_w-1:0]           add_result,
   input  logic [alu_pkg::flag_w-1:0]  add_flags,
   input  logic [alu_pkg::flag_w-1:0]  add_flag_mask,
   input  logic [data_w-1:0]           logic_result,
   input  logic [alu_pkg::flag_w-1:0]  logic_flags,
   input  logic [alu_pkg::flag_w-1:0]  logic_flag_mask,
   input  logic [data_w-1:0]           shift_result,
   input  logic [alu_pkg::flag_w-1:0]  shift_flags,
   input  logic [alu_pkg::flag_w-1:0]  shift_flag_mask,
   input  logic [data_w-1:0]           simd_result,
   input  logic                        in_valid,
   output logic                        in_ready,
   output logic                        out_valid,
   input  logic                        out_ready,
   output logic [data_w-1:0]           alu_out,
   output logic [alu_pkg::flag_w-1:0]  set_eflags,
   output logic [alu_pkg::flag_w-1:0]  eflags_out
);

   logic [data_w-1:0]          sel_result;
   logic [alu_pkg::flag_w-1:0] sel_flags;
   logic [alu_pkg::flag_w-1:0] sel_mask;
   logic [alu_pkg::flag_w-1:0] eflags_next;
   logic                       load;

   // result mux, packed ops and pass write no flags
   always_comb begin
      sel_result = a.word;
      sel_flags  = '0;
      sel_mask   = '0;
      case (alu_op)
         alu_pkg::op_add: begin
            sel_result = add_result;
            sel_flags  = add_flags;
            sel_mask   = add_flag_mask;
         end
         alu_pkg::op_and, alu_pkg::op_or, alu_pkg::op_not: begin
            sel_result = logic_result;
            sel_flags  = logic_flags;
            sel_mask   = logic_flag_mask;
         end
         alu_pkg::op_sal, alu_pkg::op_sar: begin
            sel_result = shift_result;
            sel_flags  = shift_flags;
            sel_mask   = shift_flag_mask;
         end
         alu_pkg::op_paddw, alu_pkg::op_paddd, alu_pkg::op_pcmp: begin
            sel_result = simd_result;
         end
         default: begin
            sel_result = a.word;
         end
      endcase
   end

   // even parity of the low byte, only where pf is written
   always_comb begin
      eflags_next = sel_flags;
      eflags_next[alu_pkg::flag_pf] = sel_mask[alu_pkg::flag_pf] & ~(^sel_result[7:0]);
   end

   // stage can take a beat when empty or draining
   assign in_ready = out_ready | ~out_valid;
   assign load     = in_valid & in_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (in_ready) begin
         out_valid <= in_valid;
      end
   end

   // held while stalled
   always_ff @(posedge clk) begin
      if (load) begin
         alu_out    <= sel_result;
         set_eflags <= sel_mask;
         eflags_out <= eflags_next;
      end
   end

endmodule

//--- alu_top.sv
`timescale 1ns/1ps

module alu_top #(
   parameter int data_w = alu_pkg::data_w
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        in_valid,
   output logic                        in_ready,
   input  alu_pkg::alu_word_u          a,
   input  alu_pkg::alu_word_u          b,
   input  logic [2:0]                  opsize,
   input  logic [15:0]                 opcode,
   input  logic [3:0]                  alu_op,
   output logic                        out_valid,
   input  logic                        out_ready,
   output logic [data_w-1:0]           alu_out,
   output logic [alu_pkg::flag_w-1:0]  set_eflags,
   output logic [alu_pkg::flag_w-1:0]  eflags_out
);

   logic [data_w-1:0]          add_result;
   logic [alu_pkg::flag_w-1:0] add_flags;
   logic [alu_pkg::flag_w-1:0] add_flag_mask;
   logic [data_w-1:0]          logic_result;
   logic [alu_pkg::flag_w-1:0] logic_flags;
   logic [alu_pkg::flag_w-1:0] logic_flag_mask;
   logic [data_w-1:0]          shift_result;
   logic [alu_pkg::flag_w-1:0] shift_flags;
   logic [alu_pkg::flag_w-1:0] shift_flag_mask;
   logic [data_w-1:0]          simd_result;

   // scalar add
   int_adder #(.data_w(data_w)) i_int_adder (
      .a         (a),
      .b         (b),
      .opsize    (opsize),
      .result    (add_result),
      .flags     (add_flags),
      .flag_mask (add_flag_mask)
   );

   // and / or / not
   logic_unit #(.data_w(data_w)) i_logic_unit (
      .a         (a),
      .b         (b),
      .opsize    (opsize),
      .alu_op    (alu_op),
      .result    (logic_result),
      .flags     (logic_flags),
      .flag_mask (logic_flag_mask)
   );

   // sal / sar
   shifter #(.data_w(data_w)) i_shifter (
      .a         (a),
      .b         (b),
      .opsize    (opsize),
      .alu_op    (alu_op),
      .result    (shift_result),
      .flags     (shift_flags),
      .flag_mask (shift_flag_mask)
   );

   // packed lanes, no flags
   simd_unit #(.data_w(data_w)) i_simd_unit (
      .a      (a),
      .b      (b),
      .alu_op (alu_op),
      .opcode (opcode),
      .result (simd_result)
   );

   // select, parity and output register
   alu_result_stage #(.data_w(data_w)) i_alu_result_stage (
      .clk             (clk),
      .rst_n           (rst_n),
      .alu_op          (alu_op),
      .a               (a),
      .add_result      (add_result),
      .add_flags       (add_flags),
      .add_flag_mask   (add_flag_mask),
      .logic_result    (logic_result),
      .logic_flags     (logic_flags),
      .logic_flag_mask (logic_flag_mask),
      .shift_result    (shift_result),
      .shift_flags     (shift_flags),
      .shift_flag_mask (shift_flag_mask),
      .simd_result     (simd_result),
      .in_valid        (in_valid),
      .in_ready        (in_ready),
      .out_valid       (out_valid),
      .out_ready       (out_ready),
      .alu_out         (alu_out),
      .set_eflags      (set_eflags),
      .eflags_out      (eflags_out)
   );

endmodule

//--- tb_alu_top.sv
`timescale 1ns/1ps

module tb_alu_top;

   localparam int clk_period   = 4;
   localparam int reset_cycles = 10;
   localparam int n_tests      = 26;
   // 40 cycles per table entry, back-pressure included
   localparam int wd_cycles    = reset_cycles + 40 * n_tests;

   logic        clk;
   logic        rst_n;
   logic        in_valid;
   logic        in_ready;
   logic [63:0] a;
   logic [63:0] b;
   logic [2:0]  opsize;
   logic [15:0] opcode;
   logic [3:0]  alu_op;
   logic        out_valid;
   logic        out_ready;
   logic [63:0] alu_out;
   logic [5:0]  set_eflags;
   logic [5:0]  eflags_out;

   // stimulus and expected results, one row per test
   string       vec_name  [n_tests];
   logic [3:0]  vec_op    [n_tests];
   logic [2:0]  vec_size  [n_tests];
   logic [63:0] vec_a     [n_tests];
   logic [63:0] vec_b     [n_tests];
   logic [15:0] vec_opc   [n_tests];
   logic [63:0] vec_out   [n_tests];
   logic [5:0]  vec_mask  [n_tests];
   logic [5:0]  vec_flags [n_tests];

   int          n_loaded;
   int          out_idx;
   int          pass_count;
   int          fail_count;
   int          misc_errors;
   int          seed;
   logic        took;
   // copy of a stalled beat
   logic        held;
   logic [63:0] held_out;
   logic [5:0]  held_mask;
   logic [5:0]  held_flags;

   alu_top #(.data_w(64)) i_alu_top (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .a          (a),
      .b          (b),
      .opsize     (opsize),
      .opcode     (opcode),
      .alu_op     (alu_op),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .alu_out    (alu_out),
      .set_eflags (set_eflags),
      .eflags_out (eflags_out)
   );

   task automatic add_vector(input string name, input logic [3:0] op, input logic [2:0] size,
                             input logic [63:0] va, input logic [63:0] vb,
                             input logic [15:0] opc, input logic [63:0] exp_out,
                             input logic [5:0] exp_mask, input logic [5:0] exp_flags);
      vec_name[n_loaded]  = name;
      vec_op[n_loaded]    = op;
      vec_size[n_loaded]  = size;
      vec_a[n_loaded]     = va;
      vec_b[n_loaded]     = vb;
      vec_opc[n_loaded]   = opc;
      vec_out[n_loaded]   = exp_out;
      vec_mask[n_loaded]  = exp_mask;
      vec_flags[n_loaded] = exp_flags;
      n_loaded++;
   endtask

   // compare the beat leaving the stage with the next row
   task automatic check_beat();
      bit bad;
      bad = 1'b0;
      if (alu_out !== vec_out[out_idx]) begin
         $display("** Error %s: alu_out expected %h, actual %h",
                  vec_name[out_idx], vec_out[out_idx], alu_out);
         bad = 1'b1;
      end
      if (set_eflags !== vec_mask[out_idx]) begin
         $display("** Error %s: set_eflags expected %h, actual %h",
                  vec_name[out_idx], vec_mask[out_idx], set_eflags);
         bad = 1'b1;
      end
      if (eflags_out !== vec_flags[out_idx]) begin
         $display("** Error %s: eflags_out expected %h, actual %h",
                  vec_name[out_idx], vec_flags[out_idx], eflags_out);
         bad = 1'b1;
      end
      if (bad) begin
         fail_count++;
         $display("test %0d %s: failed", out_idx, vec_name[out_idx]);
      end else begin
         pass_count++;
         $display("test %0d %s: ok", out_idx, vec_name[out_idx]);
      end
      out_idx++;
   endtask

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   // random back-pressure
   initial begin
      seed      = 69;
      out_ready = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         // stall roughly one cycle in four
         out_ready = (($random(seed) & 3) != 0);
      end
   end

   // output monitor, samples one ns before the edge
   initial begin
      held = 1'b0;
      forever begin
         @(posedge clk);
         #3;
         if (rst_n && out_valid) begin
            if (held && (alu_out !== held_out || set_eflags !== held_mask ||
                         eflags_out !== held_flags)) begin
               $display("output changed while stalled on test %0d", out_idx);
               misc_errors++;
            end
            if (out_idx >= n_loaded) begin
               $display("extra output beat after the last test");
               misc_errors++;
               held = 1'b0;
            end else if (out_ready) begin
               check_beat();
               held = 1'b0;
            end else begin
               held       = 1'b1;
               held_out   = alu_out;
               held_mask  = set_eflags;
               held_flags = eflags_out;
            end
         end
      end
   end

   initial begin
      #(wd_cycles * clk_period);
      $display("timeout: only %0d of %0d results seen", out_idx, n_loaded);
      $display("Test failures found");
      $finish;
   end

   initial begin
      rst_n       = 1'b0;
      in_valid    = 1'b0;
      a           = '0;
      b           = '0;
      opsize      = '0;
      opcode      = '0;
      alu_op      = '0;
      n_loaded    = 0;
      out_idx     = 0;
      pass_count  = 0;
      fail_count  = 0;
      misc_errors = 0;

      // add, flags {of sf zf af cf pf}
      add_vector("add8_carry", 4'd1, 3'd1, 64'hff, 64'h01, 16'h0, 64'h0, 6'h3f, 6'h0f);
      add_vector("add8_ovf", 4'd1, 3'd1, 64'h7f, 64'h01, 16'h0, 64'h80, 6'h3f, 6'h34);
      add_vector("add16_af", 4'd1, 3'd2, 64'haaaa_0000_5555_1234, 64'h0fff, 16'h0,
                 64'h2233, 6'h3f, 6'h05);
      add_vector("add16_ovf_zero", 4'd1, 3'd2, 64'h8000, 64'h8000, 16'h0, 64'h0, 6'h3f, 6'h2b);
      add_vector("add32_carry", 4'd1, 3'd3, 64'hffff_ffff, 64'h2, 16'h0, 64'h1, 6'h3f, 6'h06);
      add_vector("add32_ovf", 4'd1, 3'd3, 64'h7fff_ffff, 64'h1, 16'h0, 64'h8000_0000,
                 6'h3f, 6'h35);
      // logic ops leave af alone, not writes nothing
      add_vector("and8", 4'd2, 3'd1, 64'h0000_1234_5678_00f3, 64'h0f8f, 16'h0, 64'h83,
                 6'h3b, 6'h10);
      add_vector("and16", 4'd2, 3'd2, 64'hffff_1234, 64'hff00, 16'h0, 64'h1200, 6'h3b, 6'h01);
      add_vector("or16_zero", 4'd8, 3'd2, 64'hffff_0000_ffff_0000, 64'h1234_0000_0000_0000,
                 16'h0, 64'h0, 6'h3b, 6'h09);
      add_vector("or32", 4'd8, 3'd3, 64'h8000_0000, 64'h55, 16'h0, 64'h8000_0055, 6'h3b, 6'h11);
      add_vector("not8", 4'd7, 3'd1, 64'h0f0f, 64'h0, 16'h0, 64'hf0, 6'h00, 6'h00);
      add_vector("not32", 4'd7, 3'd3, 64'h1234_5678_0000_ffff, 64'h0, 16'h0, 64'hffff_0000,
                 6'h00, 6'h00);
      // shifts, count from b[4:0]
      add_vector("sal_cnt0", 4'd12, 3'd1, 64'h1122_3344_5566_7788, 64'h20, 16'h0,
                 64'h1122_3344_5566_7788, 6'h00, 6'h00);
      add_vector("sal8_cnt1", 4'd12, 3'd1, 64'h41, 64'h1, 16'h0, 64'h82, 6'h3b, 6'h31);
      add_vector("sal16_cnt4", 4'd12, 3'd2, 64'h9abc, 64'h4, 16'h0, 64'habc0, 6'h1b, 6'h13);
      add_vector("sal8_cnt9", 4'd12, 3'd1, 64'hff, 64'h9, 16'h0, 64'h0, 6'h1b, 6'h09);
      add_vector("sar_cnt0", 4'd13, 3'd2, 64'h8000_0000_0000_8080, 64'h40, 16'h0,
                 64'h8000_0000_0000_8080, 6'h00, 6'h00);
      add_vector("sar8_cnt1", 4'd13, 3'd1, 64'h81, 64'h1, 16'h0, 64'hc0, 6'h3b, 6'h13);
      add_vector("sar16_cnt3", 4'd13, 3'd2, 64'h8f05, 64'h3, 16'h0, 64'hf1e0, 6'h1b, 6'h12);
      add_vector("sar8_cnt20", 4'd13, 3'd1, 64'h90, 64'h14, 16'h0, 64'hff, 6'h1b, 6'h13);
      // packed lanes
      add_vector("paddw", 4'd9, 3'd3, 64'hffff_0001_7fff_1234, 64'h0001_0001_0001_1111,
                 16'h0, 64'h0000_0002_8000_2345, 6'h00, 6'h00);
      add_vector("paddd", 4'd10, 3'd3, 64'hffff_ffff_8000_0001, 64'h0000_0001_ffff_ffff,
                 16'h0, 64'h0000_0000_8000_0000, 6'h00, 6'h00);
      add_vector("pmaxsw", 4'd11, 3'd3, 64'h8000_0005_ffff_7fff, 64'h7fff_fffb_0001_8000,
                 16'h0fee, 64'h7fff_0005_0001_7fff, 6'h00, 6'h00);
      add_vector("pminsw", 4'd11, 3'd3, 64'h8000_0005_ffff_7fff, 64'h7fff_fffb_0001_8000,
                 16'h0fea, 64'h8000_fffb_ffff_8000, 6'h00, 6'h00);
      // pass and an unused code return a
      add_vector("pass", 4'd0, 3'd3, 64'hdead_beef_0123_4567, 64'hffff, 16'h0,
                 64'hdead_beef_0123_4567, 6'h00, 6'h00);
      add_vector("unused_op", 4'd15, 3'd3, 64'h0f0e_0d0c_0b0a_0908, 64'h1, 16'h0,
                 64'h0f0e_0d0c_0b0a_0908, 6'h00, 6'h00);

      repeat (reset_cycles) @(posedge clk);
      #1;
      rst_n = 1'b1;
      if (out_valid !== 1'b0) begin
         $display("out_valid is not low after reset");
         misc_errors++;
      end
      if (in_ready !== 1'b1) begin
         $display("in_ready is not high after reset");
         misc_errors++;
      end

      // hold each row until the stage takes it
      for (int i = 0; i < n_loaded; i++) begin
         in_valid = 1'b1;
         alu_op   = vec_op[i];
         opsize   = vec_size[i];
         a        = vec_a[i];
         b        = vec_b[i];
         opcode   = vec_opc[i];
         do begin
            #2;
            took = in_ready;
            @(posedge clk);
            #1;
         end while (!took);
      end
      in_valid = 1'b0;

      wait (out_idx == n_loaded);
      // a few more cycles to catch stray beats
      repeat (4) @(posedge clk);
      $display("%0d tests, %0d passed, %0d failed, %0d other errors",
               n_loaded, pass_count, fail_count, misc_errors);
      if (fail_count == 0 && misc_errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

//--- list.f
alu_pkg.sv
int_adder.sv
logic_unit.sv
shifter.sv
simd_unit.sv
alu_result_stage.sv
alu_top.sv
tb_alu_top.sv

//--- Makefile
# Verilator build and run of the ALU testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f list.f --top-module tb_alu_top -o sim_alu

run: compile
	@out="$$(./obj_dir/sim_alu)"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
